// ==== bench/cpu_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpu_tb;

    import cpu_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int SAMPLE_DELAY = 10;
    localparam int RESET_CYCLES = 16;
    localparam int PROG_WORDS   = 256;
    localparam int CYCLE_LIMIT  = RESET_CYCLES + PROG_WORDS + 64;

    localparam int T_RESET   = 0;
    localparam int T_COUNT   = 1;
    localparam int T_MOVE    = 2;
    localparam int T_ARITH   = 3;
    localparam int T_LOGIC   = 4;
    localparam int T_INVALID = 5;
    localparam int NUM_TESTS = 6;

    logic        CLK;
    logic        arst_n;
    instr_u      instruction;
    logic [31:0] pc;
    wb_t         wb;

    instr_u      imem [PROG_WORDS];
    logic [7:0]  model_regs [8];
    logic [31:0] exp_pc;
    int          cycles;
    int          checks [NUM_TESTS];
    int          errors [NUM_TESTS];
    string       test_name [NUM_TESTS];

    cpu DUT (
        .CLK         (CLK),
        .arst_n      (arst_n),
        .instruction (instruction),
        .pc          (pc),
        .wb          (wb)
    );

    initial begin
        CLK = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) CLK = ~CLK;
        end
    end

    // Run limit, a little past reset plus one pass over the program.
    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge CLK);
            cycles++;
        end
        $display("Run stopped: no result after %0d clock cycles", cycles);
        $display("TESTBENCH FAILED");
        $finish;
    end

    // **************************************************
    // Program and reference model
    // **************************************************

    // Mostly valid opcodes. All other fields stay random.
    task automatic fill_program();
        logic [31:0] word;
        for (int i = 0; i < PROG_WORDS; i++) begin
            word = $urandom;
            if ($urandom_range(9, 0) < 9) begin
                word[31:24] = 8'($urandom_range(5, 0));
            end else begin
                word[31:24] = 8'($urandom_range(255, 6));
            end
            imem[i] = word;
        end
    endtask

    task automatic report_mismatch(input int test, input string what,
                                   input logic [31:0] expected, input logic [31:0] actual);
        errors[test]++;
        $display("CHECK FAILED %s: %s expected %0h actual %0h",
                 test_name[test], what, expected, actual);
    endtask

    task automatic check_instruction(input instr_u ins);
        logic [7:0] a;
        logic [7:0] b;
        wb_t        exp;
        int         test;
        a         = model_regs[ins.r.src1];
        b         = model_regs[ins.r.src2];
        exp.valid = 1'b1;
        exp.addr  = ins.r.dest;
        exp.data  = 8'd0;
        test      = T_INVALID;
        case (ins.r.opcode)
            loadi: begin
                exp.data = ins.i.imm;
                test     = T_MOVE;
            end
            // Copies the second source register.
            mov: begin
                exp.data = b;
                test     = T_MOVE;
            end
            add: begin
                exp.data = a + b;
                test     = T_ARITH;
            end
            sub: begin
                exp.data = a - b;
                test     = T_ARITH;
            end
            and_op: begin
                exp.data = a & b;
                test     = T_LOGIC;
            end
            or_op: begin
                exp.data = a | b;
                test     = T_LOGIC;
            end
            default: begin
                exp.valid = 1'b0;
            end
        endcase
        checks[test]++;
        if (wb.valid !== exp.valid) begin
            report_mismatch(test, "wb.valid", 32'(exp.valid), 32'(wb.valid));
        end
        if (exp.valid) begin
            if (wb.addr !== exp.addr) begin
                report_mismatch(test, "wb.addr", 32'(exp.addr), 32'(wb.addr));
            end
            if (wb.data !== exp.data) begin
                report_mismatch(test, "wb.data", 32'(exp.data), 32'(wb.data));
            end
            // Takes effect at the coming edge.
            model_regs[exp.addr] = exp.data;
        end
    endtask

    task automatic report_test(input int test);
        if (checks[test] == 0) begin
            errors[test]++;
            $display("Test %s ran no checks", test_name[test]);
        end
        $display("Test %s %0d checks, %0d errors: %s", test_name[test],
                 checks[test], errors[test], (errors[test] == 0) ? "pass" : "fail");
    endtask

    // **************************************************
    // Main sequence
    // **************************************************

    initial begin
        int passed;
        int total_checks;
        int total_errors;
        void'($urandom(32'hcdcba387));
        test_name   = '{"reset", "counting", "loadi_mov", "add_sub", "and_or", "invalid"};
        arst_n      = 1'b0;
        instruction = '0;
        exp_pc      = 32'd0;
        for (int r = 0; r < 8; r++) begin
            model_regs[r] = 8'd0;
        end
        for (int t = 0; t < NUM_TESTS; t++) begin
            checks[t] = 0;
            errors[t] = 0;
        end
        fill_program();

        repeat (RESET_CYCLES) begin
            @(negedge CLK);
            instruction = imem[pc[7:0]];
            #SAMPLE_DELAY;
            checks[T_RESET]++;
            if (pc !== 32'd0) begin
                report_mismatch(T_RESET, "pc", 32'd0, pc);
            end
            if (wb.valid !== 1'b0) begin
                report_mismatch(T_RESET, "wb.valid", 32'd0, 32'(wb.valid));
            end
        end

        // First cycle out of reset writes nothing.
        @(negedge CLK);
        arst_n      = 1'b1;
        instruction = imem[pc[7:0]];
        #SAMPLE_DELAY;
        checks[T_RESET]++;
        if (pc !== 32'd0) begin
            report_mismatch(T_RESET, "pc", 32'd0, pc);
        end
        if (wb.valid !== 1'b0) begin
            report_mismatch(T_RESET, "wb.valid", 32'd0, 32'(wb.valid));
        end
        report_test(T_RESET);
        exp_pc = 32'd1;

        repeat (PROG_WORDS - 1) begin
            @(negedge CLK);
            instruction = imem[pc[7:0]];
            #SAMPLE_DELAY;
            checks[T_COUNT]++;
            if (pc !== exp_pc) begin
                report_mismatch(T_COUNT, "pc", exp_pc, pc);
            end
            check_instruction(instruction);
            exp_pc = exp_pc + 32'd1;
        end

        for (int t = T_COUNT; t < NUM_TESTS; t++) begin
            report_test(t);
        end
        passed       = 0;
        total_checks = 0;
        total_errors = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            total_checks += checks[t];
            total_errors += errors[t];
            if (errors[t] == 0) begin
                passed++;
            end
        end
        $display("Tests: %0d run, %0d passed, %0d failed; %0d checks, %0d errors",
                 NUM_TESTS, passed, NUM_TESTS - passed, total_checks, total_errors);
        if (total_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds and runs the cpu testbench with Verilator.
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    -f sources.f \
    --top-module cpu_tb \
    --Mdir obj_dir \
    -o cpu_tb_sim

./obj_dir/cpu_tb_sim | tee sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
    echo "Simulation reported failure, see sim.log"
    exit 1
fi

if ! grep -q "TESTBENCH PASSED" sim.log; then
    echo "Simulation ended without a result, see sim.log"
    exit 1
fi

echo "Simulation finished without errors"

// ==== source/alu.sv ====
`timescale 1ns/100ps
`default_nettype none

module alu (
    input  wire               [7:0] operand1,
    input  wire               [7:0] operand2,
    input  wire                     comp_select,
    input  cpu_pkg::alu_op_e        alu_op,
    output logic              [7:0] result
);

    import cpu_pkg::*;

    logic [7:0] operand2_sel;

    // Two's complement negation for subtract.
    assign operand2_sel = comp_select ? (~operand2 + 8'd1) : operand2;

    always_comb begin
        case (alu_op)
            alu_forward: begin
                result = operand2_sel;
            end
            alu_add: begin
                result = operand1 + operand2_sel;   // wraps at 8 bits
            end
            alu_and: begin
                result = operand1 & operand2_sel;
            end
            alu_or: begin
                result = operand1 | operand2_sel;
            end
            default: begin
                result = 8'd0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== source/control_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module control_unit (
    input  cpu_pkg::opcode_e opcode,
    output cpu_pkg::ctrl_t   ctrl
);

    import cpu_pkg::*;

    always_comb begin
        // Unknown opcodes write nothing.
        ctrl = '0;

        case (opcode)
            loadi: begin
                ctrl.write_enable     = 1'b1;
                ctrl.immediate_select = 1'b1;
                ctrl.alu_op           = alu_forward;
            end

            mov: begin
                ctrl.write_enable = 1'b1;
                ctrl.alu_op       = alu_forward;
            end

            add: begin
                ctrl.write_enable = 1'b1;
                ctrl.alu_op       = alu_add;
            end

            // Subtract is add with operand 2 negated.
            sub: begin
                ctrl.write_enable = 1'b1;
                ctrl.comp_select  = 1'b1;
                ctrl.alu_op       = alu_add;
            end

            and_op: begin
                ctrl.write_enable = 1'b1;
                ctrl.alu_op       = alu_and;
            end

            or_op: begin
                ctrl.write_enable = 1'b1;
                ctrl.alu_op       = alu_or;
            end

            default: begin
                ctrl = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== source/cpu.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpu (
    input  wire              CLK,
    input  wire              arst_n,
    input  cpu_pkg::instr_u  instruction,
    output logic      [31:0] pc,
    output cpu_pkg::wb_t     wb
);

    import cpu_pkg::*;

    ctrl_t      ctrl;
    logic [7:0] read_data1;
    logic [7:0] read_data2;
    logic [7:0] operand2;
    logic [7:0] result;
    logic       running;

    program_counter u_pc (
        .CLK    (CLK),
        .arst_n (arst_n),
        .pc     (pc)
    );

    control_unit u_ctrl (
        .opcode (opcode_e'(instruction.r.opcode)),
        .ctrl   (ctrl)
    );

    reg_file u_regs (
        .CLK        (CLK),
        .arst_n     (arst_n),
        .read_addr1 (instruction.r.src1),
        .read_addr2 (instruction.r.src2),
        .read_data1 (read_data1),
        .read_data2 (read_data2),
        .wb         (wb)
    );

    // Immediate or register for operand 2.
    assign operand2 = ctrl.immediate_select ? instruction.i.imm : read_data2;

    alu u_alu (
        .operand1    (read_data1),
        .operand2    (operand2),
        .comp_select (ctrl.comp_select),
        .alu_op      (ctrl.alu_op),
        .result      (result)
    );

    // Set at the first edge out of reset.
    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            running <= 1'b0;
        end else begin
            running <= 1'b1;
        end
    end

    assign wb.valid = ctrl.write_enable & running;
    assign wb.addr  = instruction.r.dest;
    assign wb.data  = result;

endmodule

`default_nettype wire

// ==== source/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    // **************************************************
    // Opcodes and ALU operations
    // **************************************************

    typedef enum logic [7:0] {
        loadi  = 8'd0,
        mov    = 8'd1,
        add    = 8'd2,
        sub    = 8'd3,
        and_op = 8'd4,
        or_op  = 8'd5
    } opcode_e;

    typedef enum logic [2:0] {
        alu_forward = 3'b000,
        alu_add     = 3'b001,
        alu_and     = 3'b010,
        alu_or      = 3'b011
    } alu_op_e;

    // **************************************************
    // Instruction word
    // **************************************************

    // Register form: two source registers.
    typedef struct packed {
        logic [7:0] opcode;
        logic [4:0] unused_hi;
        logic [2:0] dest;
        logic [4:0] unused_mid;
        logic [2:0] src1;
        logic [4:0] unused_lo;
        logic [2:0] src2;
    } instr_reg_t;

    // Immediate form: 8-bit constant in the low byte.
    typedef struct packed {
        logic [7:0] opcode;
        logic [4:0] unused_hi;
        logic [2:0] dest;
        logic [7:0] unused_mid;
        logic [7:0] imm;
    } instr_imm_t;

    typedef union packed {
        instr_reg_t r;
        instr_imm_t i;
    } instr_u;

    // **************************************************
    // Control and writeback
    // **************************************************

    typedef struct packed {
        logic    write_enable;
        logic    comp_select;
        logic    immediate_select;
        alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed {
        logic       valid;
        logic [2:0] addr;
        logic [7:0] data;
    } wb_t;

endpackage

`default_nettype wire

// ==== source/program_counter.sv ====
`timescale 1ns/100ps
`default_nettype none

module program_counter (
    input  wire         CLK,
    input  wire         arst_n,
    output logic [31:0] pc
);

    logic [31:0] pc_next;

    // Increment adder.
    assign pc_next = pc + 32'd1;

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            pc <= 32'd0;
        end else begin
            pc <= pc_next;
        end
    end

    // No jumps, so every edge out of reset counts up by one.
    pc_counts_up: assert property (
        @(posedge CLK) disable iff (!arst_n)
        $past(arst_n) |-> pc == $past(pc) + 32'd1
    ) else $error("pc did not advance by one");

endmodule

`default_nettype wire

// ==== source/reg_file.sv ====
`timescale 1ns/100ps
`default_nettype none

module reg_file (
    input  wire            CLK,
    input  wire            arst_n,
    input  wire      [2:0] read_addr1,
    input  wire      [2:0] read_addr2,
    output logic     [7:0] read_data1,
    output logic     [7:0] read_data2,
    input  cpu_pkg::wb_t   wb
);

    logic [7:0] regs [8];

    // Combinational read ports.
    assign read_data1 = regs[read_addr1];
    assign read_data2 = regs[read_addr2];

    // Single write port, taken at the rising edge.
    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= 8'd0;
            end
        end else if (wb.valid) begin
            regs[wb.addr] <= wb.data;
        end
    end

    // **************************************************
    // Checks
    // **************************************************

    // A write must target a known register.
    wb_addr_known: assert property (
        @(posedge CLK) disable iff (!arst_n)
        wb.valid |-> !$isunknown(wb.addr)
    ) else $error("write to unknown register address");

endmodule

`default_nettype wire

// ==== sources.f ====
source/cpu_pkg.sv
source/program_counter.sv
source/control_unit.sv
source/reg_file.sv
source/alu.sv
source/cpu.sv
bench/cpu_tb.sv
